// ==== common/isa_pkg.sv ====
package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // Major opcodes at instruction bits [6:0]
    typedef enum logic [6:0] {
        NOP    = 7'b0000000,
        LOAD   = 7'b0000011,
        OP_IMM = 7'b0010011,
        STORE  = 7'b0100011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JALR   = 7'b1100111,
        JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLT, SLL, SRL, SRA, PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        EQ = 3'b000,
        NE = 3'b001,
        LT = 3'b100,
        GE = 3'b101
    } br_funct_e;

    // funct3 of OP and OP-IMM
    localparam logic [2:0] F3_ADD = 3'b000;   // add/sub
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SR  = 3'b101;   // srl/sra
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } instr_t;

endpackage

// ==== common/pipe_pkg.sv ====
package pipe_pkg;

    typedef enum logic [1:0] {
        FROM_RF  = 2'd0,
        FROM_EX  = 2'd1,
        FROM_MEM = 2'd2
    } fwd_sel_e;

    typedef struct packed {
        logic           valid;
        isa_pkg::word_t pc;
        isa_pkg::word_t pc4;
        isa_pkg::word_t ir;
    } if_id_t;

    typedef struct packed {
        logic               valid;
        isa_pkg::opcode_e   opcode;
        isa_pkg::alu_op_e   alu_op;
        isa_pkg::br_funct_e br_funct;
        isa_pkg::word_t     pc;
        isa_pkg::word_t     pc4;
        isa_pkg::word_t     data1;
        isa_pkg::word_t     data2;
        isa_pkg::word_t     imm;
        isa_pkg::reg_addr_t rd;
        logic               wr_reg;
        logic               use_imm;
    } id_ex_t;

    typedef struct packed {
        logic               valid;
        isa_pkg::opcode_e   opcode;
        isa_pkg::word_t     pc4;
        isa_pkg::word_t     c;    // ALU result or address
        isa_pkg::word_t     b;    // Store data
        isa_pkg::reg_addr_t rd;
        logic               wr_reg;
    } ex_mem_t;

    typedef struct packed {
        logic               valid;
        isa_pkg::word_t     value;
        isa_pkg::reg_addr_t rd;
        logic               wr_reg;
    } mem_wb_t;

endpackage

// ==== src.f ====
common/isa_pkg.sv
common/pipe_pkg.sv
src/fetch/fetch_stage.sv
src/decode/reg_file.sv
src/decode/decode_stage.sv
src/hazard_unit.sv
src/execute/execute_stage.sv
src/memory/mem_stage.sv
src/top.sv
tests/tb_ref_pkg.sv
tests/tb_top.sv

// ==== src/decode/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               hold,
    input  logic               stall,
    input  logic               flush,
    input  pipe_pkg::if_id_t   if_id,
    output isa_pkg::reg_addr_t rs1,
    output isa_pkg::reg_addr_t rs2,
    input  isa_pkg::word_t     rf_data1,
    input  isa_pkg::word_t     rf_data2,
    input  pipe_pkg::fwd_sel_e fwd1,
    input  pipe_pkg::fwd_sel_e fwd2,
    input  isa_pkg::word_t     ex_fwd,
    input  isa_pkg::word_t     mem_fwd,
    output pipe_pkg::id_ex_t   id_ex
);
    import isa_pkg::*;
    import pipe_pkg::*;

    instr_t  ins;
    word_t   imm_i;
    word_t   imm_s;
    word_t   imm_b;
    word_t   imm_u;
    word_t   imm_j;
    opcode_e opcode;
    alu_op_e alu_op;
    word_t   imm;
    logic    wr_reg;
    logic    use_imm;
    word_t   data1;
    word_t   data2;

    function automatic alu_op_e arith_op(logic [2:0] f3, logic alt);
        case (f3)
            F3_ADD:  return alt ? SUB : ADD;
            F3_SLL:  return SLL;
            F3_SLT:  return SLT;
            F3_XOR:  return XOR;
            F3_SR:   return alt ? SRA : SRL;
            F3_OR:   return OR;
            F3_AND:  return AND;
            default: return ADD;   // sltu not supported
        endcase
    endfunction

    function automatic word_t pick(fwd_sel_e sel, word_t rf_val, word_t ex_val,
                                   word_t mem_val);
        case (sel)
            FROM_EX:  return ex_val;
            FROM_MEM: return mem_val;
            default:  return rf_val;
        endcase
    endfunction

    assign ins = instr_t'(if_id.ir);
    assign rs1 = ins.rs1;
    assign rs2 = ins.rs2;

    assign imm_i = {{20{if_id.ir[31]}}, if_id.ir[31:20]};
    assign imm_s = {{20{if_id.ir[31]}}, if_id.ir[31:25], if_id.ir[11:7]};
    assign imm_b = {{19{if_id.ir[31]}}, if_id.ir[31], if_id.ir[7], if_id.ir[30:25],
                    if_id.ir[11:8], 1'b0};
    assign imm_u = {if_id.ir[31:12], 12'h000};
    assign imm_j = {{11{if_id.ir[31]}}, if_id.ir[31], if_id.ir[19:12], if_id.ir[20],
                    if_id.ir[30:21], 1'b0};

    always_comb begin
        opcode  = NOP;
        alu_op  = ADD;
        imm     = imm_i;
        use_imm = 1'b0;
        wr_reg  = 1'b0;
        case (ins.opcode)
            OP: begin
                opcode = OP;
                alu_op = arith_op(ins.funct3, ins.funct7[5]);
                wr_reg = 1'b1;
            end
            OP_IMM: begin
                opcode  = OP_IMM;
                // Bit 30 only selects sra as there is no subi
                alu_op  = arith_op(ins.funct3, ins.funct7[5] && ins.funct3 != F3_ADD);
                use_imm = 1'b1;
                wr_reg  = 1'b1;
            end
            LUI: begin
                opcode  = LUI;
                alu_op  = PASS_B;
                imm     = imm_u;
                use_imm = 1'b1;
                wr_reg  = 1'b1;
            end
            LOAD: begin
                opcode  = LOAD;
                use_imm = 1'b1;
                wr_reg  = 1'b1;
            end
            STORE: begin
                opcode  = STORE;
                imm     = imm_s;
                use_imm = 1'b1;
            end
            BRANCH: begin
                opcode = BRANCH;
                imm    = imm_b;
            end
            JAL: begin
                opcode = JAL;
                imm    = imm_j;
                wr_reg = 1'b1;
            end
            JALR: begin
                opcode = JALR;
                wr_reg = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        data1 = pick(fwd1, rf_data1, ex_fwd, mem_fwd);
        data2 = pick(fwd2, rf_data2, ex_fwd, mem_fwd);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (!hold) begin
            id_ex <= '{
                valid:    if_id.valid && !stall && !flush,   // Bubble
                opcode:   opcode,
                alu_op:   alu_op,
                br_funct: br_funct_e'(ins.funct3),
                pc:       if_id.pc,
                pc4:      if_id.pc4,
                data1:    data1,
                data2:    data2,
                imm:      imm,
                rd:       ins.rd,
                wr_reg:   wr_reg,
                use_imm:  use_imm
            };
        end
    end

endmodule

// ==== src/decode/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic               clk,
    input  logic               rst_n,
    input  isa_pkg::reg_addr_t rs1,
    input  isa_pkg::reg_addr_t rs2,
    input  logic               wr_en,
    input  isa_pkg::reg_addr_t wr_addr,
    input  isa_pkg::word_t     wr_data,
    output isa_pkg::word_t     data1,
    output isa_pkg::word_t     data2
);
    import isa_pkg::*;

    word_t regs [32];

    // Same-cycle write passes straight through
    function automatic word_t read_port(reg_addr_t a, logic we, reg_addr_t wa, word_t wd,
                                        word_t stored);
        if (a == '0) begin
            return '0;
        end else if (we && wa == a) begin
            return wd;
        end
        return stored;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    always_comb begin
        data1 = read_port(rs1, wr_en, wr_addr, wr_data, regs[rs1]);
        data2 = read_port(rs2, wr_en, wr_addr, wr_data, regs[rs2]);
    end

endmodule

// ==== src/execute/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              hold,
    input  pipe_pkg::id_ex_t  id_ex,
    output logic              redirect,
    output isa_pkg::word_t    target,
    output isa_pkg::word_t    ex_fwd,
    output pipe_pkg::ex_mem_t ex_mem
);
    import isa_pkg::*;

    word_t op_b;
    word_t alu_c;
    word_t jalr_sum;
    logic  taken;
    logic  is_jump;

    assign op_b = id_ex.use_imm ? id_ex.imm : id_ex.data2;

    always_comb begin
        case (id_ex.alu_op)
            SUB:     alu_c = id_ex.data1 - op_b;
            AND:     alu_c = id_ex.data1 & op_b;
            OR:      alu_c = id_ex.data1 | op_b;
            XOR:     alu_c = id_ex.data1 ^ op_b;
            SLT:     alu_c = {31'b0, $signed(id_ex.data1) < $signed(op_b)};
            SLL:     alu_c = id_ex.data1 << op_b[4:0];
            SRL:     alu_c = id_ex.data1 >> op_b[4:0];
            SRA:     alu_c = $signed(id_ex.data1) >>> op_b[4:0];
            PASS_B:  alu_c = op_b;   // lui
            default: alu_c = id_ex.data1 + op_b;
        endcase
    end

    always_comb begin
        case (id_ex.br_funct)
            EQ:      taken = id_ex.data1 == id_ex.data2;
            NE:      taken = id_ex.data1 != id_ex.data2;
            LT:      taken = $signed(id_ex.data1) < $signed(id_ex.data2);
            GE:      taken = $signed(id_ex.data1) >= $signed(id_ex.data2);
            default: taken = 1'b0;
        endcase
    end

    assign is_jump  = id_ex.opcode == JAL || id_ex.opcode == JALR;
    assign redirect = id_ex.valid && (is_jump || (id_ex.opcode == BRANCH && taken));

    assign jalr_sum = id_ex.data1 + id_ex.imm;
    assign target   = (id_ex.opcode == JALR) ? {jalr_sum[31:1], 1'b0} : id_ex.pc + id_ex.imm;

    assign ex_fwd = is_jump ? id_ex.pc4 : alu_c;   // Link value for jumps

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else if (!hold) begin
            ex_mem <= '{
                valid:  id_ex.valid,
                opcode: id_ex.opcode,
                pc4:    id_ex.pc4,
                c:      alu_c,
                b:      id_ex.data2,
                rd:     id_ex.rd,
                wr_reg: id_ex.wr_reg
            };
        end
    end

endmodule

// ==== src/fetch/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage #(
    parameter isa_pkg::word_t RESET_PC = 32'h0001_0000
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             hold,
    input  logic             stall,
    input  logic             flush,
    input  logic             redirect,
    input  isa_pkg::word_t   target,
    input  isa_pkg::word_t   instr,
    output isa_pkg::word_t   pc,
    output pipe_pkg::if_id_t if_id
);
    import isa_pkg::*;

    word_t pc4;

    assign pc4 = pc + 32'd4;

    // Redirect wins over a load-use stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (!hold && (redirect || !stall)) begin
            pc <= redirect ? target : pc4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_id <= '0;
        end else if (!hold) begin
            if (flush) begin
                if_id.valid <= 1'b0;   // Wrong-path fetch
            end else if (!stall) begin
                if_id <= '{valid: 1'b1, pc: pc, pc4: pc4, ir: instr};
            end
        end
    end

endmodule

// ==== src/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit (
    input  isa_pkg::reg_addr_t rs1,
    input  isa_pkg::reg_addr_t rs2,
    input  pipe_pkg::id_ex_t   id_ex,
    input  pipe_pkg::ex_mem_t  ex_mem,
    input  logic               redirect,
    input  logic               ACKI_n,
    input  logic               mem_wait,
    output pipe_pkg::fwd_sel_e fwd1,
    output pipe_pkg::fwd_sel_e fwd2,
    output logic               stall,
    output logic               flush,
    output logic               hold
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic load_in_ex;

    // Youngest producer first
    function automatic fwd_sel_e src_of(reg_addr_t rs, id_ex_t ex, ex_mem_t mem);
        if (rs == '0) begin
            return FROM_RF;
        end else if (ex.valid && ex.wr_reg && ex.rd == rs) begin
            return FROM_EX;
        end else if (mem.valid && mem.wr_reg && mem.rd == rs) begin
            return FROM_MEM;
        end
        return FROM_RF;
    endfunction

    always_comb begin
        fwd1 = src_of(rs1, id_ex, ex_mem);
        fwd2 = src_of(rs2, id_ex, ex_mem);
    end

    assign load_in_ex = id_ex.valid && id_ex.opcode == LOAD && id_ex.rd != '0;

    // Load data only exists from MEM onward
    assign stall = load_in_ex && (id_ex.rd == rs1 || id_ex.rd == rs2);
    assign flush = redirect;
    assign hold  = ACKI_n || mem_wait;

endmodule

// ==== src/memory/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               hold,
    input  pipe_pkg::ex_mem_t  ex_mem,
    output isa_pkg::word_t     DAD,
    output logic               MREQ,
    output logic               WRITE,
    output logic [1:0]         SIZE,
    inout  wire [31:0]         DDT,
    input  logic               ACKD_n,
    output logic               mem_wait,
    output isa_pkg::word_t     mem_fwd,
    output logic               wr_en,
    output isa_pkg::reg_addr_t wr_addr,
    output isa_pkg::word_t     wr_data
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic    done_q;   // Access finished while the pipe was held
    word_t   ld_q;
    word_t   load_data;
    word_t   wb_value;
    mem_wb_t mem_wb;

    assign MREQ  = ex_mem.valid && !done_q &&
                   (ex_mem.opcode == LOAD || ex_mem.opcode == STORE);
    assign WRITE = MREQ && ex_mem.opcode == STORE;
    assign DAD   = ex_mem.c;
    assign SIZE  = 2'b10;   // Word only
    assign DDT   = WRITE ? ex_mem.b : 'z;

    assign mem_wait = MREQ && ACKD_n;

    // Keeps a store from being issued twice when fetch is the one waiting
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q <= 1'b0;
        end else if (!hold) begin
            done_q <= 1'b0;
        end else if (MREQ && !ACKD_n) begin
            done_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (hold && MREQ && !ACKD_n) begin
            ld_q <= DDT;
        end
    end

    assign load_data = done_q ? ld_q : DDT;

    always_comb begin
        case (ex_mem.opcode)
            LOAD:      wb_value = load_data;
            JAL, JALR: wb_value = ex_mem.pc4;
            default:   wb_value = ex_mem.c;
        endcase
    end

    assign mem_fwd = wb_value;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb <= '0;
        end else if (!hold) begin
            mem_wb <= '{
                valid:  ex_mem.valid,
                value:  wb_value,
                rd:     ex_mem.rd,
                wr_reg: ex_mem.wr_reg
            };
        end
    end

    // Writeback
    assign wr_en   = mem_wb.valid && mem_wb.wr_reg;
    assign wr_addr = mem_wb.rd;
    assign wr_data = mem_wb.value;

endmodule

// ==== src/top.sv ====
`timescale 1ns/1ps

module top #(
    parameter isa_pkg::word_t RESET_PC = 32'h0001_0000
) (
    input  logic           clk,
    input  logic           rst_n,
    output isa_pkg::word_t IAD,
    input  isa_pkg::word_t IDT,
    input  logic           ACKI_n,
    output isa_pkg::word_t DAD,
    inout  wire [31:0]     DDT,
    output logic           MREQ,
    output logic           WRITE,
    output logic [1:0]     SIZE,
    input  logic           ACKD_n
);
    import isa_pkg::*;
    import pipe_pkg::*;

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rf_data1;
    word_t     rf_data2;
    fwd_sel_e  fwd1;
    fwd_sel_e  fwd2;
    word_t     ex_fwd;
    word_t     mem_fwd;
    logic      stall;
    logic      flush;
    logic      hold;
    logic      redirect;
    word_t     target;
    logic      mem_wait;
    logic      wr_en;
    reg_addr_t wr_addr;
    word_t     wr_data;

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
        .clk(clk), .rst_n(rst_n),
        .hold(hold), .stall(stall), .flush(flush),
        .redirect(redirect), .target(target),
        .instr(IDT), .pc(IAD), .if_id(if_id)
    );

    decode_stage u_decode (
        .clk(clk), .rst_n(rst_n),
        .hold(hold), .stall(stall), .flush(flush),
        .if_id(if_id), .rs1(rs1), .rs2(rs2),
        .rf_data1(rf_data1), .rf_data2(rf_data2),
        .fwd1(fwd1), .fwd2(fwd2),
        .ex_fwd(ex_fwd), .mem_fwd(mem_fwd),
        .id_ex(id_ex)
    );

    reg_file u_rf (
        .clk(clk), .rst_n(rst_n),
        .rs1(rs1), .rs2(rs2),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .data1(rf_data1), .data2(rf_data2)
    );

    hazard_unit u_hazard (
        .rs1(rs1), .rs2(rs2),
        .id_ex(id_ex), .ex_mem(ex_mem),
        .redirect(redirect), .ACKI_n(ACKI_n), .mem_wait(mem_wait),
        .fwd1(fwd1), .fwd2(fwd2),
        .stall(stall), .flush(flush), .hold(hold)
    );

    execute_stage u_execute (
        .clk(clk), .rst_n(rst_n), .hold(hold),
        .id_ex(id_ex),
        .redirect(redirect), .target(target),
        .ex_fwd(ex_fwd), .ex_mem(ex_mem)
    );

    mem_stage u_mem (
        .clk(clk), .rst_n(rst_n), .hold(hold),
        .ex_mem(ex_mem),
        .DAD(DAD), .MREQ(MREQ), .WRITE(WRITE), .SIZE(SIZE),
        .DDT(DDT), .ACKD_n(ACKD_n),
        .mem_wait(mem_wait), .mem_fwd(mem_fwd),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
    );

endmodule

// ==== tests/tb_ref_pkg.sv ====
package tb_ref_pkg;
    import isa_pkg::*;

    typedef word_t words_t[$];

    // Data memory fill that the model also uses for unwritten words
    function automatic word_t init_word(word_t a);
        return (a * 32'h9e37_79b1) ^ 32'h1357_9bdf;
    endfunction

    function automatic word_t r_type(logic [6:0] f7, logic [2:0] f3, int rd, int rs1, int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OP};
    endfunction

    function automatic word_t i_type(opcode_e op, logic [2:0] f3, int rd, int rs1, int imm);
        return {imm[11:0], 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic word_t s_type(int rs2, int rs1, int imm);
        logic [11:0] w;
        w = imm[11:0];
        return {w[11:5], 5'(rs2), 5'(rs1), 3'b010, w[4:0], STORE};
    endfunction

    function automatic word_t b_type(logic [2:0] f3, int rs1, int rs2, int imm);
        logic [12:0] w;
        w = imm[12:0];
        return {w[12], w[10:5], 5'(rs2), 5'(rs1), f3, w[4:1], w[11], BRANCH};
    endfunction

    function automatic word_t u_type(int rd, logic [19:0] imm);
        return {imm, 5'(rd), LUI};
    endfunction

    function automatic word_t j_type(int rd, int imm);
        logic [20:0] w;
        w = imm[20:0];
        return {w[20], w[10:1], w[11], w[19:12], 5'(rd), JAL};
    endfunction

    function automatic word_t load_word(int rd, int rs1, int imm);
        return i_type(LOAD, 3'b010, rd, rs1, imm);
    endfunction

    function automatic words_t program_words(int n);
        words_t p;
        case (n)
            2: p = {
                i_type(OP_IMM, F3_ADD, 10, 0, 'h100), i_type(OP_IMM, F3_ADD, 1, 0, 'h123),
                u_type(2, 20'h80000), r_type(7'h00, F3_ADD, 3, 1, 2), s_type(3, 10, 0),
                r_type(7'h20, F3_ADD, 4, 3, 1), s_type(4, 10, 4),
                r_type(7'h00, F3_XOR, 5, 4, 3), r_type(7'h00, F3_OR, 6, 5, 2),
                r_type(7'h00, F3_AND, 7, 6, 3), s_type(7, 10, 8),
                r_type(7'h00, F3_SLT, 8, 2, 1), r_type(7'h00, F3_SLL, 9, 1, 8),
                r_type(7'h00, F3_SR, 12, 2, 8), r_type(7'h20, F3_SR, 13, 2, 8),
                s_type(9, 10, 12), s_type(12, 10, 16), s_type(13, 10, 20),
                s_type(6, 10, 28), s_type(8, 10, 32),
                i_type(OP_IMM, F3_ADD, 14, 13, -1), i_type(OP_IMM, F3_SLT, 15, 14, 0),
                i_type(OP_IMM, F3_XOR, 16, 14, 'h555), i_type(OP_IMM, F3_OR, 17, 16, 'h0f0),
                i_type(OP_IMM, F3_AND, 18, 17, 'h7f3), i_type(OP_IMM, F3_SLL, 19, 18, 3),
                i_type(OP_IMM, F3_SR, 20, 19, 5), i_type(OP_IMM, F3_SR, 21, 2, 'h404),
                s_type(15, 10, 36), s_type(16, 10, 40), s_type(17, 10, 44),
                s_type(18, 10, 48), s_type(19, 10, 52), s_type(21, 10, 60),
                u_type(11, 20'h00001), s_type(20, 11, -4), j_type(0, 0)
            };
            3: p = {
                i_type(OP_IMM, F3_ADD, 10, 0, 'h100), load_word(1, 10, 0),
                r_type(7'h00, F3_ADD, 2, 1, 1), load_word(3, 10, 4), s_type(3, 10, 8),
                load_word(4, 10, 8), load_word(5, 10, 12), i_type(OP_IMM, F3_ADD, 6, 5, 1),
                s_type(2, 10, 16), s_type(6, 10, 20), load_word(7, 10, 16),
                s_type(7, 10, 24), u_type(11, 20'h00001), s_type(4, 11, -4), j_type(0, 0)
            };
            default: p = {
                i_type(OP_IMM, F3_ADD, 10, 0, 'h100), i_type(OP_IMM, F3_ADD, 1, 0, 5),
                i_type(OP_IMM, F3_ADD, 2, 0, -3), b_type(3'b000, 1, 2, 8), s_type(1, 10, 0),
                b_type(3'b001, 1, 2, 12), s_type(2, 10, 4), s_type(2, 10, 8),
                b_type(3'b100, 2, 1, 12), s_type(1, 10, 12), s_type(1, 10, 16),
                b_type(3'b101, 2, 1, 8), s_type(2, 10, 20), j_type(5, 12),
                s_type(1, 10, 24), s_type(1, 10, 28), s_type(5, 10, 32),
                i_type(OP_IMM, F3_ADD, 6, 5, 28), i_type(JALR, 3'b000, 7, 6, 0),
                s_type(1, 10, 44), s_type(1, 10, 48), s_type(7, 10, 40),
                u_type(11, 20'h00001), s_type(1, 11, -4), j_type(0, 0)
            };
        endcase
        return p;
    endfunction

    function automatic word_t model_alu(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Instruction-set model that runs until the store to 0xffc
    function automatic void run_model(input words_t prog, input word_t base,
                                      output words_t st_addr, output words_t st_data);
        word_t x [32];
        word_t mem [word_t];
        word_t pc;
        word_t ir;
        word_t a;
        word_t b;
        word_t res;
        word_t nxt;
        word_t ea;
        word_t imm_i;
        word_t imm_s;
        word_t imm_b;
        word_t imm_j;
        int    idx;
        logic  wr;
        logic  taken;
        st_addr = {};
        st_data = {};
        foreach (x[i]) begin
            x[i] = '0;
        end
        pc = base;
        for (int n = 0; n < 4000; n++) begin
            idx = int'((pc - base) >> 2);
            ir = (idx >= 0 && idx < prog.size()) ? prog[idx] : 32'h0000_0013;
            a = x[ir[19:15]];
            b = x[ir[24:20]];
            imm_i = {{20{ir[31]}}, ir[31:20]};
            imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            imm_b = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
            imm_j = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
            res = '0;
            wr = 1'b1;
            nxt = pc + 4;
            case (ir[6:0])
                OP:     res = model_alu(ir[14:12], ir[30], a, b);
                OP_IMM: res = model_alu(ir[14:12], ir[30] && ir[14:12] == 3'b101, a, imm_i);
                LUI:    res = {ir[31:12], 12'h000};
                LOAD: begin
                    ea = a + imm_i;
                    res = mem.exists(ea) ? mem[ea] : init_word(ea);
                end
                STORE: begin
                    wr = 1'b0;
                    ea = a + imm_s;
                    mem[ea] = b;
                    st_addr.push_back(ea);
                    st_data.push_back(b);
                    if (ea == 32'h0000_0ffc) begin
                        return;
                    end
                end
                BRANCH: begin
                    wr = 1'b0;
                    case (ir[14:12])
                        3'b000:  taken = a == b;
                        3'b001:  taken = a != b;
                        3'b100:  taken = $signed(a) < $signed(b);
                        3'b101:  taken = $signed(a) >= $signed(b);
                        default: taken = 1'b0;
                    endcase
                    if (taken) begin
                        nxt = pc + imm_b;
                    end
                end
                JAL: begin
                    res = pc + 4;
                    nxt = pc + imm_j;
                end
                JALR: begin
                    res = pc + 4;
                    nxt = (a + imm_i) & ~32'd1;
                end
                default: wr = 1'b0;
            endcase
            if (wr && ir[11:7] != 5'd0) begin
                x[ir[11:7]] = res;
            end
            pc = nxt;
        end
    endfunction

endpackage

// ==== tests/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;
    import isa_pkg::*;
    import tb_ref_pkg::*;

    localparam word_t RESET_PC = 32'h0001_0000;
    localparam int    MAX_WAIT = 2000;

    logic       clk;
    logic       rst_n;
    word_t      iad;
    word_t      idt;
    logic       acki_n;
    word_t      dad;
    wire [31:0] ddt;
    logic       mreq;
    logic       write;
    logic [1:0] size;
    logic       ackd_n;
    int         ack_mode;   // 0 ready, 1 random waits, 2 fetch held off
    word_t      rom [256];
    word_t      ram [1024];
    word_t      rom_idx;
    words_t     got_addr;
    words_t     got_data;
    int         bus_errs;
    int         pass_cnt;
    int         fail_cnt;

    top #(.RESET_PC(RESET_PC)) u_dut (
        .clk(clk), .rst_n(rst_n),
        .IAD(iad), .IDT(idt), .ACKI_n(acki_n),
        .DAD(dad), .DDT(ddt), .MREQ(mreq), .WRITE(write), .SIZE(size),
        .ACKD_n(ackd_n)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    assign rom_idx = (iad - RESET_PC) >> 2;
    assign idt = (rom_idx < 256) ? rom[rom_idx[7:0]] : 32'h0000_0013;
    assign ddt = (mreq && !write) ? ram[dad[11:2]] : 'z;

    // Acknowledges driven 2 ns after the edge
    initial begin
        void'($urandom(32'had2e_d195));
        forever begin
            @(posedge clk);
            #2;
            case (ack_mode)
                1: begin
                    acki_n = ($urandom % 4) == 0;
                    ackd_n = ($urandom % 3) == 0;
                end
                2: begin
                    acki_n = 1'b1;
                    ackd_n = 1'b0;
                end
                default: begin
                    acki_n = 1'b0;
                    ackd_n = 1'b0;
                end
            endcase
        end
    end

    // Data bus monitor with store recorder and RAM write
    always @(posedge clk) begin
        if (rst_n && mreq) begin
            assert (size === 2'b10) else begin
                $display("error: SIZE got %h expected %h", size, 2'b10);
                bus_errs++;
            end
        end
        if (rst_n && mreq && write && !ackd_n) begin
            got_addr.push_back(dad);
            got_data.push_back(ddt);
            ram[dad[11:2]] <= ddt;
        end
    end

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
    endtask

    task automatic report_test(input string name, input int errs);
        if (errs == 0) begin
            pass_cnt++;
            $display("%-24s ok", name);
        end else begin
            fail_cnt++;
            $display("%-24s failed, %0d errors", name, errs);
        end
    endtask

    task automatic check_reset();
        int errs;
        errs = 0;
        ack_mode = 2;
        apply_reset();
        @(negedge clk);
        assert (mreq === 1'b0) else begin
            $display("error: MREQ got %h expected %h", mreq, 1'b0);
            errs++;
        end
        assert (write === 1'b0) else begin
            $display("error: WRITE got %h expected %h", write, 1'b0);
            errs++;
        end
        assert (iad === RESET_PC) else begin
            $display("error: IAD got %h expected %h", iad, RESET_PC);
            errs++;
        end
        report_test("reset state", errs);
    endtask

    task automatic run_program(input string name, input int n, input int mode);
        words_t prog;
        words_t exp_addr;
        words_t exp_data;
        int     errs;
        int     t;
        prog = program_words(n);
        run_model(prog, RESET_PC, exp_addr, exp_data);
        foreach (rom[i]) begin
            rom[i] = (i < prog.size()) ? prog[i] : 32'h0000_0013;
        end
        foreach (ram[i]) begin
            ram[i] = init_word(word_t'(i) << 2);
        end
        got_addr = {};
        got_data = {};
        bus_errs = 0;
        ack_mode = mode;
        apply_reset();
        errs = 0;
        t = 0;
        while (!(got_addr.size() > 0 && got_addr[$] == 32'h0000_0ffc) && t < MAX_WAIT) begin
            @(negedge clk);
            t++;
        end
        if (!(got_addr.size() > 0 && got_addr[$] == 32'h0000_0ffc)) begin
            $display("%s: the final store to 0xffc never came within %0d cycles", name, MAX_WAIT);
            errs++;
        end else begin
            assert (got_addr.size() == exp_addr.size()) else begin
                $display("error: store count got %h expected %h", got_addr.size(),
                         exp_addr.size());
                errs++;
            end
            for (int i = 0; i < got_addr.size() && i < exp_addr.size(); i++) begin
                assert (got_addr[i] == exp_addr[i]) else begin
                    $display("error: DAD store %0d got %h expected %h", i, got_addr[i],
                             exp_addr[i]);
                    errs++;
                end
                assert (got_data[i] == exp_data[i]) else begin
                    $display("error: DDT store %0d got %h expected %h", i, got_data[i],
                             exp_data[i]);
                    errs++;
                end
            end
        end
        errs += bus_errs;
        report_test(name, errs);
    endtask

    initial begin
        rst_n = 1'b0;
        acki_n = 1'b1;
        ackd_n = 1'b1;
        ack_mode = 2;
        bus_errs = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        foreach (rom[i]) begin
            rom[i] = 32'h0000_0013;
        end
        foreach (ram[i]) begin
            ram[i] = init_word(word_t'(i) << 2);
        end
        check_reset();
        run_program("alu chain", 2, 0);
        run_program("load use", 3, 0);
        run_program("branch and jump", 4, 0);
        run_program("alu chain, waits", 2, 1);
        run_program("load use, waits", 3, 1);
        run_program("branch and jump, waits", 4, 1);
        $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
